// File: udp_echo.f
udp_echo_pkg.sv
udp_port_filter.sv
udp_reply_header.sv
udp_payload_fifo.sv
udp_echo_top.sv
tb_clock_gen.sv
udp_echo_tb.sv

// File: Bender.yml
package:
  name: udp_echo

sources:
  - udp_echo_pkg.sv
  - udp_port_filter.sv
  - udp_reply_header.sv
  - udp_payload_fifo.sv
  - udp_echo_top.sv
  - target: test
    files:
      - tb_clock_gen.sv
      - udp_echo_tb.sv

// File: udp_echo_tb.sv
// UDP echo testbench
`timescale 1ns/1ps

module udp_echo_tb import udp_echo_pkg::*;;

    localparam udp_port_t ECHO_PORT  = 16'd1234;
    localparam ip_addr_t  LOCAL_IP   = 32'hc0a8_0180;
    localparam int        FIFO_DEPTH = 16;
    // Upper bound on payload bytes over all tests
    localparam int        MAX_BYTES  = 8 + 10 + 6 + 12 * 16 + 40;
    localparam int        WATCHDOG_CYCLES = MAX_BYTES * 20 + 1000;

    logic clk;
    logic rst;
    logic i_rx_hdr_valid, o_rx_hdr_ready;
    ip_addr_t i_rx_ip_source_ip;
    udp_port_t i_rx_udp_source_port, i_rx_udp_dest_port;
    udp_len_t i_rx_udp_length;
    byte_t i_rx_payload_tdata;
    logic i_rx_payload_tvalid, i_rx_payload_tlast, i_rx_payload_tuser, o_rx_payload_tready;
    logic o_tx_hdr_valid, i_tx_hdr_ready;
    ip_addr_t o_tx_ip_source_ip, o_tx_ip_dest_ip;
    udp_port_t o_tx_udp_source_port, o_tx_udp_dest_port;
    udp_len_t o_tx_udp_length;
    byte_t o_tx_payload_tdata;
    logic o_tx_payload_tvalid, o_tx_payload_tlast, o_tx_payload_tuser, i_tx_payload_tready;

    // Reference model queues
    // Header entry is {src ip, dst ip, src port, dst port, length}
    logic [111:0] exp_hdr_q [$];
    logic [9:0]   exp_byte_q [$];
    logic [111:0] exp_hdr, act_hdr, prev_hdr;
    logic [9:0]   exp_byte, act_byte, prev_byte;
    logic         hdr_stalled = 1'b0;
    logic         byte_stalled = 1'b0;
    logic [31:0]  lfsr_state = 32'h5e5;
    int           ready_mode = 0;
    int           bytes_in = 0;
    int           value_errors = 0;
    int           protocol_errors = 0;
    string        test_name = "reset";
    int           n;

    tb_clock_gen u_tb_clock_gen (.clk(clk), .rst(rst));

    udp_echo_top #(
        .ECHO_PORT (ECHO_PORT),
        .LOCAL_IP  (LOCAL_IP),
        .FIFO_DEPTH(FIFO_DEPTH)
    ) u_udp_echo_top (.*);

    assign act_hdr  = {o_tx_ip_source_ip, o_tx_ip_dest_ip, o_tx_udp_source_port,
                       o_tx_udp_dest_port, o_tx_udp_length};
    assign act_byte = {o_tx_payload_tuser, o_tx_payload_tlast, o_tx_payload_tdata};

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'hd000_0001;
        end
        return s >> 1;
    endfunction

    // One LFSR step per bit taken
    function automatic int unsigned rand_bits(input int nbits);
        int unsigned r;
        int k;
        r = 0;
        for (k = 0; k < nbits; k++) begin
            lfsr_state = lfsr_step(lfsr_state);
            r = (r << 1) | lfsr_state[0];
        end
        return r;
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic send_datagram(input ip_addr_t src_ip, input udp_port_t src_port,
                                 input udp_port_t dst_port, input int nbytes);
        byte_t data [$];
        logic  user [$];
        logic  fire;
        int    i;
        int    waits;
        for (i = 0; i < nbytes; i++) begin
            data.push_back(byte_t'(rand_bits(8)));
            user.push_back(rand_bits(1) == 1);
        end
        // Reply expected only for the echo port
        if (dst_port == ECHO_PORT) begin
            exp_hdr_q.push_back({LOCAL_IP, src_ip, dst_port, src_port, udp_len_t'(nbytes + 8)});
            for (i = 0; i < nbytes; i++) begin
                exp_byte_q.push_back({user[i], i == nbytes - 1, data[i]});
            end
        end
        i_rx_hdr_valid       = 1'b1;
        i_rx_ip_source_ip    = src_ip;
        i_rx_udp_source_port = src_port;
        i_rx_udp_dest_port   = dst_port;
        i_rx_udp_length      = udp_len_t'(nbytes + 8);
        waits = 0;
        do begin
            @(negedge clk);
            fire = o_rx_hdr_ready;
            if (!fire) begin
                waits++;
            end
            next_cycle();
        end while (!fire);
        // Idle filter takes the header at once unless the reply header is stalled
        if (dst_port != ECHO_PORT || ready_mode != 1) begin
            assert (waits == 0) else begin
                protocol_errors++;
                $display("%s: inbound header held off while the filter was idle", test_name);
            end
        end
        i_rx_hdr_valid = 1'b0;
        for (i = 0; i < nbytes; i++) begin
            i_rx_payload_tvalid = 1'b1;
            i_rx_payload_tdata  = data[i];
            i_rx_payload_tuser  = user[i];
            i_rx_payload_tlast  = (i == nbytes - 1);
            do begin
                @(negedge clk);
                fire = o_rx_payload_tready;
                next_cycle();
            end while (!fire);
            bytes_in++;
            i_rx_payload_tvalid = 1'b0;
            if (rand_bits(2) == 0) begin
                next_cycle();
            end
        end
    endtask

    task automatic wait_drain();
        while (exp_hdr_q.size() > 0 || exp_byte_q.size() > 0) begin
            @(negedge clk);
        end
        next_cycle();
    endtask

    // Outbound ready bits drawn on the edge and driven after it
    initial begin
        logic hdr_bit;
        logic byte_bit;
        i_tx_hdr_ready      = 1'b1;
        i_tx_payload_tready = 1'b1;
        forever begin
            @(posedge clk);
            hdr_bit  = 1'b1;
            byte_bit = (ready_mode != 2);
            if (ready_mode == 1) begin
                hdr_bit  = rand_bits(2) != 0;
                byte_bit = rand_bits(2) != 0;
            end
            #2;
            i_tx_hdr_ready      = hdr_bit;
            i_tx_payload_tready = byte_bit;
        end
    end

    // Output checks sampled mid-cycle
    always @(negedge clk) begin
        if (!rst) begin
            if (o_tx_hdr_valid) begin
                assert (exp_hdr_q.size() > 0) else begin
                    protocol_errors++;
                    $display("%s: reply header appeared with no matching datagram", test_name);
                end
                if (i_tx_hdr_ready && exp_hdr_q.size() > 0) begin
                    exp_hdr = exp_hdr_q.pop_front();
                    assert (act_hdr == exp_hdr) else begin
                        value_errors++;
                        $display("error %s expected %h actual %h", test_name, exp_hdr, act_hdr);
                    end
                end
            end
            if (o_tx_payload_tvalid) begin
                assert (exp_byte_q.size() > 0) else begin
                    protocol_errors++;
                    $display("%s: payload byte appeared with no matching datagram", test_name);
                end
                if (i_tx_payload_tready && exp_byte_q.size() > 0) begin
                    exp_byte = exp_byte_q.pop_front();
                    assert (act_byte == exp_byte) else begin
                        value_errors++;
                        $display("error %s expected %h actual %h", test_name, exp_byte, act_byte);
                    end
                end
            end
            // Stalled outputs hold valid and data
            if (hdr_stalled) begin
                assert (o_tx_hdr_valid && act_hdr == prev_hdr) else begin
                    protocol_errors++;
                    $display("%s: reply header changed while stalled", test_name);
                end
            end
            if (byte_stalled) begin
                assert (o_tx_payload_tvalid && act_byte == prev_byte) else begin
                    protocol_errors++;
                    $display("%s: payload byte changed while stalled", test_name);
                end
            end
            hdr_stalled  = o_tx_hdr_valid && !i_tx_hdr_ready;
            byte_stalled = o_tx_payload_tvalid && !i_tx_payload_tready;
            prev_hdr     = act_hdr;
            prev_byte    = act_byte;
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: run still busy after %0d cycles", WATCHDOG_CYCLES);
        $display("Test failed");
        $finish;
    end

    initial begin
        i_rx_hdr_valid       = 1'b0;
        i_rx_ip_source_ip    = '0;
        i_rx_udp_source_port = '0;
        i_rx_udp_dest_port   = '0;
        i_rx_udp_length      = '0;
        i_rx_payload_tdata   = '0;
        i_rx_payload_tvalid  = 1'b0;
        i_rx_payload_tlast   = 1'b0;
        i_rx_payload_tuser   = 1'b0;
        wait (!rst);
        @(negedge clk);
        assert (!o_tx_hdr_valid && !o_tx_payload_tvalid && !o_rx_payload_tready) else begin
            protocol_errors++;
            $display("reset: outputs not idle after reset");
        end
        repeat (5) @(negedge clk);
        next_cycle();

        test_name = "echo";
        send_datagram(32'h0a00_0005, 16'd5000, ECHO_PORT, 8);
        wait_drain();

        test_name = "drop";
        send_datagram(32'h0a00_0006, 16'd5001, 16'd4321, 10);
        repeat (10) @(negedge clk);
        next_cycle();
        send_datagram(32'h0a00_0007, 16'd5002, ECHO_PORT, 6);
        wait_drain();

        // Mixed traffic under random back-pressure
        test_name = "mixed";
        ready_mode = 1;
        repeat (12) begin
            n = 1 + rand_bits(4);
            if (rand_bits(1) == 1) begin
                send_datagram(ip_addr_t'(rand_bits(32)), udp_port_t'(rand_bits(16)), ECHO_PORT, n);
            end else begin
                send_datagram(ip_addr_t'(rand_bits(32)), udp_port_t'(rand_bits(16)),
                              udp_port_t'(2000 + rand_bits(8)), n);
            end
        end
        wait_drain();
        ready_mode = 0;

        // FIFO fills with the payload output held off
        test_name = "fill";
        ready_mode = 2;
        next_cycle();
        bytes_in = 0;
        fork
            send_datagram(32'h0a00_0008, 16'd5003, ECHO_PORT, 40);
        join_none
        wait (bytes_in == FIFO_DEPTH);
        repeat (4) @(negedge clk);
        assert (!o_rx_payload_tready && bytes_in == FIFO_DEPTH) else begin
            protocol_errors++;
            $display("fill: inbound payload still accepted with the FIFO full");
        end
        next_cycle();
        ready_mode = 0;
        wait fork;
        wait_drain();

        $display("value errors: %0d, protocol errors: %0d", value_errors, protocol_errors);
        if (value_errors == 0 && protocol_errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: tb_clock_gen.sv
// Testbench clock and reset
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int HALF_PERIOD_NS = 20,
    parameter int RESET_CYCLES   = 5
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD_NS clk = ~clk;
    end

    // Reset drops a little after a rising edge, like every other input
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        rst = 1'b0;
    end

endmodule

// File: udp_echo_top.sv
// UDP echo top level
`timescale 1ns/1ps

module udp_echo_top import udp_echo_pkg::*; #(
    parameter udp_port_t ECHO_PORT  = DEFAULT_ECHO_PORT,
    parameter ip_addr_t  LOCAL_IP   = DEFAULT_LOCAL_IP,
    parameter int        FIFO_DEPTH = 256
) (
    input  logic      clk,
    input  logic      rst,

    // Inbound UDP header
    input  logic      i_rx_hdr_valid,
    output logic      o_rx_hdr_ready,
    input  ip_addr_t  i_rx_ip_source_ip,
    input  udp_port_t i_rx_udp_source_port,
    input  udp_port_t i_rx_udp_dest_port,
    input  udp_len_t  i_rx_udp_length,

    // Inbound payload
    input  byte_t     i_rx_payload_tdata,
    input  logic      i_rx_payload_tvalid,
    input  logic      i_rx_payload_tlast,
    input  logic      i_rx_payload_tuser,
    output logic      o_rx_payload_tready,

    // Outbound UDP header
    output logic      o_tx_hdr_valid,
    input  logic      i_tx_hdr_ready,
    output ip_addr_t  o_tx_ip_source_ip,
    output ip_addr_t  o_tx_ip_dest_ip,
    output udp_port_t o_tx_udp_source_port,
    output udp_port_t o_tx_udp_dest_port,
    output udp_len_t  o_tx_udp_length,

    // Outbound payload
    output byte_t     o_tx_payload_tdata,
    output logic      o_tx_payload_tvalid,
    output logic      o_tx_payload_tlast,
    output logic      o_tx_payload_tuser,
    input  logic      i_tx_payload_tready
);

    // Filter to header builder
    logic      fwd_hdr_valid;
    logic      fwd_hdr_ready;
    ip_addr_t  fwd_ip_source_ip;
    udp_port_t fwd_udp_source_port;
    udp_port_t fwd_udp_dest_port;
    udp_len_t  fwd_udp_length;

    // Filter to FIFO
    logic      wr_valid;
    logic      wr_ready;
    byte_t     wr_data;
    logic      wr_last;
    logic      wr_user;

    udp_port_filter #(
        .ECHO_PORT (ECHO_PORT)
    ) u_udp_port_filter (
        .clk                   (clk),
        .rst                   (rst),
        .i_hdr_valid           (i_rx_hdr_valid),
        .o_hdr_ready           (o_rx_hdr_ready),
        .i_ip_source_ip        (i_rx_ip_source_ip),
        .i_udp_source_port     (i_rx_udp_source_port),
        .i_udp_dest_port       (i_rx_udp_dest_port),
        .i_udp_length          (i_rx_udp_length),
        .i_payload_tdata       (i_rx_payload_tdata),
        .i_payload_tvalid      (i_rx_payload_tvalid),
        .i_payload_tlast       (i_rx_payload_tlast),
        .i_payload_tuser       (i_rx_payload_tuser),
        .o_payload_tready      (o_rx_payload_tready),
        .o_fwd_hdr_valid       (fwd_hdr_valid),
        .i_fwd_hdr_ready       (fwd_hdr_ready),
        .o_fwd_ip_source_ip    (fwd_ip_source_ip),
        .o_fwd_udp_source_port (fwd_udp_source_port),
        .o_fwd_udp_dest_port   (fwd_udp_dest_port),
        .o_fwd_udp_length      (fwd_udp_length),
        .o_wr_valid            (wr_valid),
        .i_wr_ready            (wr_ready),
        .o_wr_data             (wr_data),
        .o_wr_last             (wr_last),
        .o_wr_user             (wr_user)
    );

    udp_reply_header #(
        .LOCAL_IP (LOCAL_IP)
    ) u_udp_reply_header (
        .clk                  (clk),
        .rst                  (rst),
        .i_hdr_valid          (fwd_hdr_valid),
        .o_hdr_ready          (fwd_hdr_ready),
        .i_ip_source_ip       (fwd_ip_source_ip),
        .i_udp_source_port    (fwd_udp_source_port),
        .i_udp_dest_port      (fwd_udp_dest_port),
        .i_udp_length         (fwd_udp_length),
        .o_tx_hdr_valid       (o_tx_hdr_valid),
        .i_tx_hdr_ready       (i_tx_hdr_ready),
        .o_tx_ip_source_ip    (o_tx_ip_source_ip),
        .o_tx_ip_dest_ip      (o_tx_ip_dest_ip),
        .o_tx_udp_source_port (o_tx_udp_source_port),
        .o_tx_udp_dest_port   (o_tx_udp_dest_port),
        .o_tx_udp_length      (o_tx_udp_length)
    );

    udp_payload_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_udp_payload_fifo (
        .clk        (clk),
        .rst        (rst),
        .i_wr_valid (wr_valid),
        .o_wr_ready (wr_ready),
        .i_wr_data  (wr_data),
        .i_wr_last  (wr_last),
        .i_wr_user  (wr_user),
        .o_rd_valid (o_tx_payload_tvalid),
        .i_rd_ready (i_tx_payload_tready),
        .o_rd_data  (o_tx_payload_tdata),
        .o_rd_last  (o_tx_payload_tlast),
        .o_rd_user  (o_tx_payload_tuser)
    );

endmodule

// File: udp_payload_fifo.sv
// Synchronous payload byte FIFO
`timescale 1ns/1ps

module udp_payload_fifo import udp_echo_pkg::*; #(
    parameter int FIFO_DEPTH = 256
) (
    input  logic  clk,
    input  logic  rst,

    // Write side
    input  logic  i_wr_valid,
    output logic  o_wr_ready,
    input  byte_t i_wr_data,
    input  logic  i_wr_last,
    input  logic  i_wr_user,

    // Read side
    output logic  o_rd_valid,
    input  logic  i_rd_ready,
    output byte_t o_rd_data,
    output logic  o_rd_last,
    output logic  o_rd_user
);

    localparam int ADDR_W  = $clog2(FIFO_DEPTH);
    localparam int ENTRY_W = $bits(byte_t) + 2;

    // Entry is {user, last, data}
    logic [ENTRY_W-1:0] mem [FIFO_DEPTH];

    // One extra bit tells full from empty
    logic [ADDR_W:0]    wr_ptr;
    logic [ADDR_W:0]    rd_ptr;
    logic               full;
    logic               empty;
    logic               wr_en;
    logic               rd_en;
    logic [ENTRY_W-1:0] rd_entry;

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[ADDR_W] != rd_ptr[ADDR_W]) &&
                   (wr_ptr[ADDR_W-1:0] == rd_ptr[ADDR_W-1:0]);

    assign o_wr_ready = !full;
    assign o_rd_valid = !empty;

    assign wr_en = i_wr_valid && !full;
    assign rd_en = i_rd_ready && !empty;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr[ADDR_W-1:0]] <= {i_wr_user, i_wr_last, i_wr_data};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // Head entry read straight from the array, visible the cycle after the write
    assign rd_entry  = mem[rd_ptr[ADDR_W-1:0]];
    assign o_rd_data = rd_entry[7:0];
    assign o_rd_last = rd_entry[8];
    assign o_rd_user = rd_entry[9];

endmodule

// File: udp_reply_header.sv
// UDP reply header builder
`timescale 1ns/1ps

module udp_reply_header import udp_echo_pkg::*; #(
    parameter ip_addr_t LOCAL_IP = DEFAULT_LOCAL_IP
) (
    input  logic      clk,
    input  logic      rst,

    // Request header from the filter
    input  logic      i_hdr_valid,
    output logic      o_hdr_ready,
    input  ip_addr_t  i_ip_source_ip,
    input  udp_port_t i_udp_source_port,
    input  udp_port_t i_udp_dest_port,
    input  udp_len_t  i_udp_length,

    // Reply header out
    output logic      o_tx_hdr_valid,
    input  logic      i_tx_hdr_ready,
    output ip_addr_t  o_tx_ip_source_ip,
    output ip_addr_t  o_tx_ip_dest_ip,
    output udp_port_t o_tx_udp_source_port,
    output udp_port_t o_tx_udp_dest_port,
    output udp_len_t  o_tx_udp_length
);

    logic      full;
    logic      load;
    ip_addr_t  dest_ip_q;
    udp_port_t src_port_q;
    udp_port_t dst_port_q;
    udp_len_t  length_q;

    // Space when empty, or when the held header leaves this cycle
    assign o_hdr_ready = !full || i_tx_hdr_ready;
    assign load        = i_hdr_valid && o_hdr_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            full <= 1'b0;
        end else if (load) begin
            full <= 1'b1;
        end else if (i_tx_hdr_ready) begin
            full <= 1'b0;
        end
    end

    // Reply goes back to the sender with the ports swapped
    always_ff @(posedge clk) begin
        if (load) begin
            dest_ip_q  <= i_ip_source_ip;
            src_port_q <= i_udp_dest_port;
            dst_port_q <= i_udp_source_port;
            length_q   <= i_udp_length;
        end
    end

    assign o_tx_hdr_valid       = full;
    assign o_tx_ip_source_ip    = LOCAL_IP;
    assign o_tx_ip_dest_ip      = dest_ip_q;
    assign o_tx_udp_source_port = src_port_q;
    assign o_tx_udp_dest_port   = dst_port_q;
    assign o_tx_udp_length      = length_q;

endmodule

// File: udp_port_filter.sv
// UDP destination port filter
`timescale 1ns/1ps

module udp_port_filter import udp_echo_pkg::*; #(
    parameter udp_port_t ECHO_PORT = DEFAULT_ECHO_PORT
) (
    input  logic      clk,
    input  logic      rst,

    // Inbound header
    input  logic      i_hdr_valid,
    output logic      o_hdr_ready,
    input  ip_addr_t  i_ip_source_ip,
    input  udp_port_t i_udp_source_port,
    input  udp_port_t i_udp_dest_port,
    input  udp_len_t  i_udp_length,

    // Inbound payload
    input  byte_t     i_payload_tdata,
    input  logic      i_payload_tvalid,
    input  logic      i_payload_tlast,
    input  logic      i_payload_tuser,
    output logic      o_payload_tready,

    // Header towards the reply builder
    output logic      o_fwd_hdr_valid,
    input  logic      i_fwd_hdr_ready,
    output ip_addr_t  o_fwd_ip_source_ip,
    output udp_port_t o_fwd_udp_source_port,
    output udp_port_t o_fwd_udp_dest_port,
    output udp_len_t  o_fwd_udp_length,

    // Payload towards the FIFO
    output logic      o_wr_valid,
    input  logic      i_wr_ready,
    output byte_t     o_wr_data,
    output logic      o_wr_last,
    output logic      o_wr_user
);

    localparam logic [1:0] ST_IDLE = 2'd0;
    localparam logic [1:0] ST_KEEP = 2'd1;
    localparam logic [1:0] ST_DROP = 2'd2;

    logic [1:0] state;
    logic       port_match;
    logic       hdr_fire;
    logic       last_fire;

    assign port_match = (i_udp_dest_port == ECHO_PORT);

    // Matching headers wait for the builder, others are swallowed at once
    assign o_hdr_ready = (state == ST_IDLE) && (port_match ? i_fwd_hdr_ready : 1'b1);
    assign hdr_fire    = i_hdr_valid && o_hdr_ready;

    assign o_fwd_hdr_valid       = (state == ST_IDLE) && i_hdr_valid && port_match;
    assign o_fwd_ip_source_ip    = i_ip_source_ip;
    assign o_fwd_udp_source_port = i_udp_source_port;
    assign o_fwd_udp_dest_port   = i_udp_dest_port;
    assign o_fwd_udp_length      = i_udp_length;

    // Payload held off while idle, drained while dropping
    always_comb begin
        case (state)
            ST_KEEP: o_payload_tready = i_wr_ready;
            ST_DROP: o_payload_tready = 1'b1;
            default: o_payload_tready = 1'b0;
        endcase
    end

    assign o_wr_valid = (state == ST_KEEP) && i_payload_tvalid;
    assign o_wr_data  = i_payload_tdata;
    assign o_wr_last  = i_payload_tlast;
    assign o_wr_user  = i_payload_tuser;

    assign last_fire = i_payload_tvalid && o_payload_tready && i_payload_tlast;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (hdr_fire) begin
                        state <= port_match ? ST_KEEP : ST_DROP;
                    end
                end
                ST_KEEP, ST_DROP: begin
                    // Frame ends on the transfer of the tlast byte
                    if (last_fire) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule

// File: udp_echo_pkg.sv
// UDP echo shared types
package udp_echo_pkg;

    // IPv4 address
    typedef logic [31:0] ip_addr_t;

    // UDP port number
    typedef logic [15:0] udp_port_t;

    // UDP length field, header plus payload
    typedef logic [15:0] udp_len_t;

    // Payload byte
    typedef logic [7:0] byte_t;

    // Datagrams to this port get answered
    localparam udp_port_t DEFAULT_ECHO_PORT = 16'd1234;

    // 192.168.1.128
    localparam ip_addr_t DEFAULT_LOCAL_IP = {8'd192, 8'd168, 8'd1, 8'd128};

endpackage
